/* hdl/combo_digit_addr.sv */
/*
 * Combo counter digits
 * Centres 1 to 3 digit cells on the combo row and addresses the digit strip
 */
`timescale 1ns/1ps
`default_nettype none

module combo_digit_addr (
    input  logic [rhythm_pkg::COORD_W-1:0]      h_cnt,
    input  logic [rhythm_pkg::COORD_W-1:0]      v_cnt,
    input  logic [rhythm_pkg::STREAK_W-1:0]     streak,
    output logic                                combo,
    output logic [rhythm_pkg::COMBO_ADDR_W-1:0] combo_addr
);

    logic [3:0]                     d_ones;
    logic [3:0]                     d_tens;
    logic [3:0]                     d_hund;
    logic [3:0]                     digit;
    logic [1:0]                     n_digits;
    logic [rhythm_pkg::COORD_W-1:0] col0;
    logic [31:0]                    rel;
    logic [31:0]                    place;
    logic [31:0]                    addr_full;
    logic                           in_row;
    logic                           in_span;

    assign d_ones = 4'(streak % 10);
    assign d_tens = 4'(streak / 10 % 10);
    assign d_hund = 4'(streak / 100);

    always_comb begin
        if (streak >= 100) begin
            n_digits = 2'd3;
            col0     = rhythm_pkg::COMBO_X3;
        end else if (streak >= 10) begin
            n_digits = 2'd2;
            col0     = rhythm_pkg::COMBO_X2;
        end else begin
            n_digits = 2'd1;
            col0     = rhythm_pkg::COMBO_X1;
        end
    end

    assign in_row  = v_cnt >= rhythm_pkg::COMBO_Y0 && v_cnt <= rhythm_pkg::COMBO_Y1;
    assign rel     = 32'(h_cnt - col0);
    assign in_span = h_cnt >= col0 && rel < n_digits * rhythm_pkg::DIGIT_W;

    // 0 is the ones place, counted from the right end of the group
    assign place = n_digits - 1 - rel / rhythm_pkg::DIGIT_W;

    always_comb begin
        case (place)
            32'd0:   digit = d_ones;
            32'd1:   digit = d_tens;
            default: digit = d_hund;
        endcase
    end

    // Glyphs sit side by side in one strip, one pixel in
    assign addr_full = rel % rhythm_pkg::DIGIT_W
                     + 32'(v_cnt - rhythm_pkg::COMBO_Y0) * rhythm_pkg::COMBO_STRIP_W
                     + digit * rhythm_pkg::DIGIT_W + 1;

    assign combo      = streak != '0 && in_row && in_span;
    assign combo_addr = (in_row && in_span) ? addr_full[rhythm_pkg::COMBO_ADDR_W-1:0] : '0;

endmodule

`default_nettype wire

/* hdl/hit_feedback.sv */
/*
 * Hit feedback effects
 * Frame timer per hit, growing ring for good and ok, grade label for all
 */
`timescale 1ns/1ps
`default_nettype none

module hit_feedback (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                frame_tick,
    input  logic                                hit_take,
    input  rhythm_pkg::hit_grade_t              hit_grade,
    input  logic [rhythm_pkg::COORD_W-1:0]      h_cnt,
    input  logic [rhythm_pkg::COORD_W-1:0]      v_cnt,
    output logic                                fb_ring,
    output logic                                fb_label,
    output logic [rhythm_pkg::RING_ADDR_W-1:0]  fb_ring_addr,
    output logic [rhythm_pkg::LABEL_ADDR_W-1:0] fb_label_addr
);

    rhythm_pkg::hit_grade_t          grade_r;
    logic [rhythm_pkg::FX_CNT_W-1:0] fx_cnt;
    logic [rhythm_pkg::FX_CNT_W-1:0] fx_next;
    logic [rhythm_pkg::FX_CNT_W-1:0] fx_end;
    logic [rhythm_pkg::COORD_W-1:0]  dx;
    logic [rhythm_pkg::COORD_W-1:0]  dy;
    logic [31:0]                     dist2;
    logic [31:0]                     radius;
    logic [31:0]                     ring_full;
    logic [31:0]                     label_full;
    logic [1:0]                      label_idx;
    logic                            has_ring;
    logic                            ring_hit;
    logic                            label_box;
    logic                            label_show;

    always_comb begin
        case (grade_r)
            rhythm_pkg::GRADE_GOOD: fx_end = rhythm_pkg::FX_END_GOOD;
            rhythm_pkg::GRADE_OK:   fx_end = rhythm_pkg::FX_END_OK;
            default:                fx_end = rhythm_pkg::FX_END_BAD;
        endcase
    end

    assign fx_next = fx_cnt + rhythm_pkg::FX_STEP;

    always_ff @(posedge clk) begin
        if (rst) begin
            fx_cnt  <= '0;
            grade_r <= rhythm_pkg::GRADE_NONE;
        end else if (hit_take) begin
            fx_cnt  <= 7'd1;            // A new hit restarts the effect
            grade_r <= hit_grade;
        end else if (frame_tick && fx_cnt != '0) begin
            fx_cnt <= (fx_next >= fx_end) ? '0 : fx_next;
        end
    end

    assign dx = (h_cnt >= rhythm_pkg::RING_CX) ? h_cnt - rhythm_pkg::RING_CX
                                               : rhythm_pkg::RING_CX - h_cnt;
    assign dy = (v_cnt >= rhythm_pkg::RING_CY) ? v_cnt - rhythm_pkg::RING_CY
                                               : rhythm_pkg::RING_CY - v_cnt;
    assign dist2  = 32'(dx) * 32'(dx) + 32'(dy) * 32'(dy);
    assign radius = (32'(rhythm_pkg::FX_GROW_END) + 32'(fx_cnt)) >> 1;

    assign has_ring = grade_r == rhythm_pkg::GRADE_GOOD || grade_r == rhythm_pkg::GRADE_OK;
    assign ring_hit = has_ring && (
        (fx_cnt != '0 && fx_cnt <= rhythm_pkg::FX_GROW_END && dist2 < radius * radius) ||
        (fx_cnt > rhythm_pkg::FX_SHOW
            && dist2 < (rhythm_pkg::RING_W / 2) * (rhythm_pkg::RING_W / 2)));

    assign label_box = h_cnt >= rhythm_pkg::LABEL_X0
                    && h_cnt < rhythm_pkg::LABEL_X0 + rhythm_pkg::LABEL_SIZE
                    && v_cnt >= rhythm_pkg::LABEL_Y0
                    && v_cnt < rhythm_pkg::LABEL_Y0 + rhythm_pkg::LABEL_SIZE;
    assign label_show = has_ring ? fx_cnt > rhythm_pkg::FX_SHOW
                                 : (grade_r == rhythm_pkg::GRADE_BAD && fx_cnt != '0);

    // Labels stacked good, ok, bad
    assign label_idx  = grade_r - 2'd1;
    assign label_full = 32'(label_idx) * (rhythm_pkg::LABEL_SIZE * rhythm_pkg::LABEL_SIZE)
                      + 32'(h_cnt - rhythm_pkg::LABEL_X0)
                      + 32'(v_cnt - rhythm_pkg::LABEL_Y0) * rhythm_pkg::LABEL_SIZE;
    assign ring_full  = 32'(h_cnt - rhythm_pkg::RING_X0)
                      + 32'(v_cnt - rhythm_pkg::RING_Y0) * rhythm_pkg::RING_W;

    always_ff @(posedge clk) begin
        if (rst) begin
            fb_ring  <= 1'b0;
            fb_label <= 1'b0;
        end else begin
            fb_ring  <= ring_hit;
            fb_label <= label_box && label_show;
        end
    end

    always_ff @(posedge clk) begin
        fb_ring_addr  <= ring_full[rhythm_pkg::RING_ADDR_W-1:0];
        fb_label_addr <= label_full[rhythm_pkg::LABEL_ADDR_W-1:0];
    end

endmodule

`default_nettype wire

/* hdl/note_track.sv */
/*
 * Slide track window and the travelling note
 * Moves the note per frame, grades presses, plays the fly-out and flags expiry
 */
`timescale 1ns/1ps
`default_nettype none

module note_track (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                frame_tick,
    input  logic                                on_track,
    input  logic                                spawn,
    input  logic                                hit_press,
    input  logic [rhythm_pkg::COORD_W-1:0]      h_cnt,
    input  logic [rhythm_pkg::COORD_W-1:0]      v_cnt,
    output logic                                slide,
    output logic [rhythm_pkg::SLIDE_ADDR_W-1:0] slide_addr,
    output logic                                note,
    output logic [rhythm_pkg::NOTE_ADDR_W-1:0]  note_addr,
    output logic                                expired,
    output rhythm_pkg::hit_grade_t              hit_grade,
    output logic                                hit_take
);

    rhythm_pkg::note_state_t        state;
    logic [rhythm_pkg::COORD_W-1:0] x;
    logic [rhythm_pkg::COORD_W-1:0] y;
    logic [rhythm_pkg::COORD_W-1:0] box_x0;
    logic [rhythm_pkg::COORD_W-1:0] box_y0;
    logic [rhythm_pkg::COORD_W-1:0] on_frames;
    logic [4:0]                     fly_idx;
    logic [31:0]                    slide_full;
    logic [31:0]                    note_full;
    logic                           flies;

    assign slide = h_cnt >= rhythm_pkg::SLIDE_X0 && h_cnt <= rhythm_pkg::SLIDE_X1
                && v_cnt >= rhythm_pkg::SLIDE_Y0 && v_cnt <= rhythm_pkg::SLIDE_Y1;
    assign slide_full = 32'(h_cnt - rhythm_pkg::SLIDE_X0)
                      + (32'(v_cnt - rhythm_pkg::SLIDE_Y0) << 9);   // 512 per row
    assign slide_addr = slide_full[rhythm_pkg::SLIDE_ADDR_W-1:0];

    // 64x64 box around the note, clamped at the screen edge
    assign box_x0 = (x > rhythm_pkg::NOTE_HALF) ? x - rhythm_pkg::NOTE_HALF : '0;
    assign box_y0 = (y > rhythm_pkg::NOTE_HALF) ? y - rhythm_pkg::NOTE_HALF : '0;
    assign note = h_cnt >= box_x0 && h_cnt < box_x0 + (rhythm_pkg::NOTE_HALF << 1)
               && v_cnt >= box_y0 && v_cnt < box_y0 + (rhythm_pkg::NOTE_HALF << 1);
    assign note_full = 32'(h_cnt - box_x0) + (32'(v_cnt - box_y0) << 6);
    assign note_addr = note_full[rhythm_pkg::NOTE_ADDR_W-1:0];

    always_comb begin
        if (state == rhythm_pkg::NOTE_FLYING)
            hit_grade = rhythm_pkg::GRADE_NONE;      // Already taken
        else if (x >= rhythm_pkg::GOOD_LO && x <= rhythm_pkg::GOOD_HI)
            hit_grade = rhythm_pkg::GRADE_GOOD;
        else if (x >= rhythm_pkg::OK_LO && x <= rhythm_pkg::OK_HI)
            hit_grade = rhythm_pkg::GRADE_OK;
        else if (x >= rhythm_pkg::BAD_LO && x <= rhythm_pkg::BAD_HI)
            hit_grade = rhythm_pkg::GRADE_BAD;
        else
            hit_grade = rhythm_pkg::GRADE_NONE;
    end

    assign hit_take = frame_tick && hit_press && hit_grade != rhythm_pkg::GRADE_NONE;
    assign flies    = hit_take && (hit_grade == rhythm_pkg::GRADE_GOOD
                                || hit_grade == rhythm_pkg::GRADE_OK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= rhythm_pkg::NOTE_PARKED;
            x       <= rhythm_pkg::NOTE_PARK_X;
            y       <= rhythm_pkg::NOTE_Y;
            fly_idx <= '0;
        end else if (frame_tick) begin
            if (flies) begin
                state   <= rhythm_pkg::NOTE_FLYING;
                fly_idx <= '0;
            end else if (state == rhythm_pkg::NOTE_FLYING) begin
                x       <= rhythm_pkg::FLY_X[fly_idx];
                y       <= rhythm_pkg::FLY_Y[fly_idx];
                fly_idx <= fly_idx + 5'd1;
                if (fly_idx == 5'(rhythm_pkg::FLY_LEN - 1))
                    state <= rhythm_pkg::NOTE_PARKED;
            end else if (spawn) begin
                state <= rhythm_pkg::NOTE_MOVING;
                x     <= rhythm_pkg::NOTE_SPAWN_X;
                y     <= rhythm_pkg::NOTE_Y;
            end else if (state == rhythm_pkg::NOTE_MOVING && on_track) begin
                x <= x - rhythm_pkg::NOTE_STEP;
            end else begin
                state <= rhythm_pkg::NOTE_PARKED;
                x     <= rhythm_pkg::NOTE_PARK_X;
                y     <= rhythm_pkg::NOTE_Y;
            end
        end
    end

    // On-track frame count saturates just past the limit, so one pulse only
    always_ff @(posedge clk) begin
        if (rst) begin
            on_frames <= '0;
            expired   <= 1'b0;
        end else begin
            expired <= frame_tick && on_track && on_frames == rhythm_pkg::NOTE_EXPIRE_FRAMES;
            if (frame_tick) begin
                if (!on_track)
                    on_frames <= '0;
                else if (on_frames <= rhythm_pkg::NOTE_EXPIRE_FRAMES)
                    on_frames <= on_frames + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rhythm_overlay_top.sv */
/*
 * Rhythm game overlay, sprite coverage and image addresses per pixel
 */
`timescale 1ns/1ps
`default_nettype none

module rhythm_overlay_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                frame_tick,
    input  logic [rhythm_pkg::COORD_W-1:0]      h_cnt,
    input  logic [rhythm_pkg::COORD_W-1:0]      v_cnt,
    input  logic [rhythm_pkg::STREAK_W-1:0]     streak,
    input  logic                                spawn,
    input  logic                                on_track,
    input  logic                                hit_press,
    output logic                                slide,
    output logic [rhythm_pkg::SLIDE_ADDR_W-1:0] slide_addr,
    output logic                                note,
    output logic [rhythm_pkg::NOTE_ADDR_W-1:0]  note_addr,
    output logic                                expired,
    output logic                                combo,
    output logic [rhythm_pkg::COMBO_ADDR_W-1:0] combo_addr,
    output logic                                fb_ring,
    output logic                                fb_label,
    output logic [rhythm_pkg::RING_ADDR_W-1:0]  fb_ring_addr,
    output logic [rhythm_pkg::LABEL_ADDR_W-1:0] fb_label_addr
);

    rhythm_pkg::hit_grade_t hit_grade;
    logic                   hit_take;

    combo_digit_addr combo_i (
        .h_cnt      (h_cnt),
        .v_cnt      (v_cnt),
        .streak     (streak),
        .combo      (combo),
        .combo_addr (combo_addr)
    );

    note_track note_i (
        .clk        (clk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .on_track   (on_track),
        .spawn      (spawn),
        .hit_press  (hit_press),
        .h_cnt      (h_cnt),
        .v_cnt      (v_cnt),
        .slide      (slide),
        .slide_addr (slide_addr),
        .note       (note),
        .note_addr  (note_addr),
        .expired    (expired),
        .hit_grade  (hit_grade),
        .hit_take   (hit_take)
    );

    // Effect outputs lag the raster by one clock
    hit_feedback fb_i (
        .clk           (clk),
        .rst           (rst),
        .frame_tick    (frame_tick),
        .hit_take      (hit_take),
        .hit_grade     (hit_grade),
        .h_cnt         (h_cnt),
        .v_cnt         (v_cnt),
        .fb_ring       (fb_ring),
        .fb_label      (fb_label),
        .fb_ring_addr  (fb_ring_addr),
        .fb_label_addr (fb_label_addr)
    );

endmodule

`default_nettype wire

/* hdl/rhythm_pkg.sv */
/*
 * Rhythm overlay shared definitions
 * Screen placements, image strides, fly-out path and state types
 */
`default_nettype none

package rhythm_pkg;

    localparam int COORD_W  = 10;
    localparam int STREAK_W = 10;

    typedef enum logic [1:0] {GRADE_NONE, GRADE_GOOD, GRADE_OK, GRADE_BAD} hit_grade_t;
    typedef enum logic [1:0] {NOTE_PARKED, NOTE_MOVING, NOTE_FLYING} note_state_t;

    // Slide track window, image is 512 wide
    localparam logic [COORD_W-1:0] SLIDE_X0 = 10'd128;
    localparam logic [COORD_W-1:0] SLIDE_Y0 = 10'd128;
    localparam logic [COORD_W-1:0] SLIDE_X1 = 10'd639;
    localparam logic [COORD_W-1:0] SLIDE_Y1 = 10'd223;
    localparam int SLIDE_ADDR_W = 16;

    localparam logic [COORD_W-1:0] NOTE_HALF    = 10'd32;
    localparam logic [COORD_W-1:0] NOTE_STEP    = 10'd2;   // Pixels per frame
    localparam logic [COORD_W-1:0] NOTE_PARK_X  = 10'd730; // Off screen
    localparam logic [COORD_W-1:0] NOTE_SPAWN_X = 10'd672;
    localparam logic [COORD_W-1:0] NOTE_Y       = 10'd165;
    localparam logic [COORD_W-1:0] NOTE_EXPIRE_FRAMES = 10'd210;
    localparam int NOTE_ADDR_W = 12;

    // Grade windows on note x
    localparam logic [COORD_W-1:0] GOOD_LO = 10'd151;
    localparam logic [COORD_W-1:0] GOOD_HI = 10'd174;
    localparam logic [COORD_W-1:0] OK_LO   = 10'd141;
    localparam logic [COORD_W-1:0] OK_HI   = 10'd184;
    localparam logic [COORD_W-1:0] BAD_LO  = 10'd185;
    localparam logic [COORD_W-1:0] BAD_HI  = 10'd214;

    // Fly-out path after a good or ok hit
    localparam int FLY_LEN = 32;
    localparam logic [COORD_W-1:0] FLY_X [0:FLY_LEN-1] = '{
        10'd180, 10'd193, 10'd206, 10'd219, 10'd232, 10'd245, 10'd258, 10'd271,
        10'd284, 10'd297, 10'd310, 10'd323, 10'd336, 10'd349, 10'd362, 10'd375,
        10'd388, 10'd401, 10'd414, 10'd427, 10'd440, 10'd453, 10'd466, 10'd479,
        10'd492, 10'd505, 10'd518, 10'd531, 10'd544, 10'd557, 10'd570, 10'd583
    };
    localparam logic [COORD_W-1:0] FLY_Y [0:FLY_LEN-1] = '{
        10'd156, 10'd148, 10'd140, 10'd132, 10'd124, 10'd116, 10'd108, 10'd100,
        10'd92,  10'd84,  10'd76,  10'd68,  10'd60,  10'd52,  10'd44,  10'd36,
        10'd38,  10'd41,  10'd44,  10'd47,  10'd50,  10'd53,  10'd56,  10'd59,
        10'd62,  10'd65,  10'd68,  10'd71,  10'd74,  10'd77,  10'd80,  10'd83
    };

    // Combo row, first column for 3, 2 and 1 digits
    localparam logic [COORD_W-1:0] COMBO_Y0 = 10'd145;
    localparam logic [COORD_W-1:0] COMBO_Y1 = 10'd176;
    localparam logic [COORD_W-1:0] COMBO_X3 = 10'd80;
    localparam logic [COORD_W-1:0] COMBO_X2 = 10'd88;
    localparam logic [COORD_W-1:0] COMBO_X1 = 10'd96;
    localparam int DIGIT_W       = 16;
    localparam int COMBO_STRIP_W = 160;
    localparam int COMBO_ADDR_W  = 13;

    localparam logic [COORD_W-1:0] RING_CX  = 10'd166;
    localparam logic [COORD_W-1:0] RING_CY  = 10'd165;
    localparam logic [COORD_W-1:0] RING_X0  = 10'd119;
    localparam logic [COORD_W-1:0] RING_Y0  = 10'd118;
    localparam logic [COORD_W-1:0] LABEL_X0 = 10'd149;
    localparam logic [COORD_W-1:0] LABEL_Y0 = 10'd108;
    localparam int RING_W     = 96;
    localparam int LABEL_SIZE = 32;

    localparam int FX_CNT_W = 7;
    localparam logic [FX_CNT_W-1:0] FX_STEP     = 7'd6;
    localparam logic [FX_CNT_W-1:0] FX_SHOW     = 7'd32;
    localparam logic [FX_CNT_W-1:0] FX_GROW_END = 7'd48;
    localparam logic [FX_CNT_W-1:0] FX_END_GOOD = 7'd70;
    localparam logic [FX_CNT_W-1:0] FX_END_OK   = 7'd60;
    localparam logic [FX_CNT_W-1:0] FX_END_BAD  = 7'd61;
    localparam int RING_ADDR_W  = 14;
    localparam int LABEL_ADDR_W = 12;

endpackage

`default_nettype wire

/* sources.f */
hdl/rhythm_pkg.sv
hdl/combo_digit_addr.sv
hdl/note_track.sv
hdl/hit_feedback.sv
hdl/rhythm_overlay_top.sv
tests/tb_clock_gen.sv
tests/rhythm_overlay_checker.sv
tests/rhythm_overlay_assertions.sv
tests/rhythm_overlay_tb.sv

/* tests/rhythm_overlay_assertions.sv */
/*
 * Hit feedback assertions, bound into the feedback unit
 */
`timescale 1ns/1ps
`default_nettype none

module rhythm_overlay_assertions (
    input logic       clk,
    input logic       rst,
    input logic       hit_take,
    input logic [1:0] hit_grade,
    input logic       fb_ring,
    input logic       fb_label
);

    int   fail_count = 0;
    logic seen_take;

    always_ff @(posedge clk) begin
        if (rst)
            seen_take <= 1'b0;
        else if (hit_take)
            seen_take <= 1'b1;
    end

    take_has_grade: assert property (@(posedge clk) disable iff (rst)
        hit_take |-> hit_grade != 2'd0)
        else begin
            $error("hit_take with no grade");
            fail_count++;
        end

    quiet_before_hit: assert property (@(posedge clk) disable iff (rst)
        !seen_take |-> !fb_ring && !fb_label)
        else begin
            $error("feedback visible before any hit");
            fail_count++;
        end

endmodule

bind hit_feedback rhythm_overlay_assertions asrt_i (
    .clk       (clk),
    .rst       (rst),
    .hit_take  (hit_take),
    .hit_grade (hit_grade),
    .fb_ring   (fb_ring),
    .fb_label  (fb_label)
);

`default_nettype wire

/* tests/rhythm_overlay_checker.sv */
/*
 * Overlay checker
 * Compares DUT outputs with the expected values on each check request
 */
`timescale 1ns/1ps
`default_nettype none

module rhythm_overlay_checker (
    input  logic         clk,
    input  logic         chk_en,
    input  logic [3:0]   chk_kind,
    input  logic [95:0]  chk_name,
    input  logic         exp_flag,
    input  logic [31:0]  exp_val,
    input  logic         chk_val,     // Value compared as well as the flag
    input  logic [1:0]   exp_grade,
    input  logic         slide,
    input  logic [15:0]  slide_addr,
    input  logic         note,
    input  logic [11:0]  note_addr,
    input  logic [1:0]   hit_grade,
    input  logic         expired,
    input  logic         combo,
    input  logic [12:0]  combo_addr,
    input  logic         fb_ring,
    input  logic         fb_label,
    input  logic [13:0]  fb_ring_addr,
    input  logic [11:0]  fb_label_addr,
    output int           flag_errs,
    output int           value_errs
);

    localparam int K_COMBO = 0, K_SLIDE = 1, K_NOTE = 2, K_LABEL = 3;
    localparam int K_RING = 4, K_EXPIRE = 5, K_PULSES = 6;

    int pulses;

    initial begin
        flag_errs  = 0;
        value_errs = 0;
        pulses     = 0;
    end

    always @(negedge clk) begin
        logic        act_flag;
        logic [31:0] act_val;
        act_flag = 1'b1;
        act_val  = '0;
        if (expired === 1'b1)
            pulses = pulses + 1;
        if (chk_en) begin
            case (chk_kind)
                K_COMBO:  begin act_flag = combo;    act_val = 32'(combo_addr);    end
                K_SLIDE:  begin act_flag = slide;    act_val = 32'(slide_addr);    end
                K_NOTE:   begin act_flag = note;     act_val = 32'(note_addr);     end
                K_LABEL:  begin act_flag = fb_label; act_val = 32'(fb_label_addr); end
                K_RING:   begin act_flag = fb_ring;  act_val = 32'(fb_ring_addr);  end
                K_EXPIRE: act_flag = expired;
                default:  act_val = 32'(pulses);
            endcase
            if (act_flag !== exp_flag) begin
                $display("ERR %0s flag: expected %0d got %0d", chk_name, exp_flag, act_flag);
                flag_errs = flag_errs + 1;
            end
            if (chk_val && act_val !== exp_val) begin
                $display("ERR %0s value: expected %0d got %0d", chk_name, exp_val, act_val);
                value_errs = value_errs + 1;
            end
            if (chk_kind == K_NOTE && hit_grade !== exp_grade) begin
                $display("ERR %0s grade: expected %0d got %0d", chk_name, exp_grade, hit_grade);
                value_errs = value_errs + 1;
            end
            if (chk_kind == K_PULSES)
                pulses = 0;   // Next window counts afresh
        end
    end

endmodule

`default_nettype wire

/* tests/rhythm_overlay_tb.sv */
/*
 * Rhythm overlay testbench
 * Table of stimulus rows applied in a loop, frame ticks, timeout
 */
`timescale 1ns/1ps
`default_nettype none

module rhythm_overlay_tb;

    localparam int K_COMBO = 0, K_SLIDE = 1, K_NOTE = 2, K_LABEL = 3;
    localparam int K_RING = 4, K_EXPIRE = 5, K_PULSES = 6;
    localparam int OP_COMBO = 0, OP_SLIDE = 1, OP_SPAWN = 2, OP_MOVE = 3, OP_PRESS = 4;
    localparam int OP_PARK = 5, OP_LABEL = 6, OP_RING = 7, OP_EXPIRE = 8, OP_PULSES = 9;
    localparam int MAX_ROWS = 64;

    logic        clk, rst, frame_tick, spawn, on_track, hit_press;
    logic [9:0]  h_cnt, v_cnt, streak;
    logic        slide, note, expired, combo, fb_ring, fb_label;
    logic [15:0] slide_addr;
    logic [11:0] note_addr, fb_label_addr;
    logic [12:0] combo_addr;
    logic [13:0] fb_ring_addr;
    logic        chk_en, exp_flag, chk_val;
    logic [3:0]  chk_kind;
    logic [95:0] chk_name;
    logic [31:0] exp_val;
    logic [1:0]  exp_grade;
    int          flag_errs, value_errs;

    logic [95:0] t_name [MAX_ROWS];
    int t_op [MAX_ROWS], t_h [MAX_ROWS], t_v [MAX_ROWS], t_streak [MAX_ROWS];
    int t_ticks [MAX_ROWS], t_flag [MAX_ROWS], t_val [MAX_ROWS], t_cv [MAX_ROWS];
    int n_rows, note_x, cycles, limit, seed;

    tb_clock_gen clk_i (.clk(clk), .rst(rst));

    rhythm_overlay_top dut_i (
        .clk(clk), .rst(rst), .frame_tick(frame_tick), .h_cnt(h_cnt), .v_cnt(v_cnt),
        .streak(streak), .spawn(spawn), .on_track(on_track), .hit_press(hit_press),
        .slide(slide), .slide_addr(slide_addr), .note(note), .note_addr(note_addr),
        .expired(expired), .combo(combo), .combo_addr(combo_addr), .fb_ring(fb_ring),
        .fb_label(fb_label), .fb_ring_addr(fb_ring_addr), .fb_label_addr(fb_label_addr)
    );

    rhythm_overlay_checker chk_i (
        .clk(clk), .chk_en(chk_en), .chk_kind(chk_kind), .chk_name(chk_name),
        .exp_flag(exp_flag), .exp_val(exp_val), .chk_val(chk_val), .exp_grade(exp_grade),
        .slide(slide), .slide_addr(slide_addr), .note(note), .note_addr(note_addr),
        .hit_grade(dut_i.note_i.hit_grade), .expired(expired), .combo(combo),
        .combo_addr(combo_addr), .fb_ring(fb_ring), .fb_label(fb_label),
        .fb_ring_addr(fb_ring_addr), .fb_label_addr(fb_label_addr),
        .flag_errs(flag_errs), .value_errs(value_errs)
    );

    function automatic int grade_of(input int x);
        if (x >= 151 && x <= 174) return 1;
        if ((x >= 141 && x <= 150) || (x >= 175 && x <= 184)) return 2;
        if (x >= 185 && x <= 214) return 3;
        return 0;
    endfunction

    function automatic int digit_count(input int s);
        return (s >= 100) ? 3 : (s >= 10) ? 2 : 1;
    endfunction

    function automatic int combo_col(input int s);
        return (digit_count(s) == 3) ? 80 : (digit_count(s) == 2) ? 88 : 96;
    endfunction

    // Digit under pixel h with cells counted from the left
    function automatic int combo_addr_of(input int s, input int h, input int v);
        int k;
        int p;
        k = (h - combo_col(s)) / 16;
        p = (digit_count(s) - 1 - k == 2) ? 100 : (digit_count(s) - 1 - k == 1) ? 10 : 1;
        return (h - combo_col(s)) % 16 + (v - 145) * 160 + (s / p % 10) * 16 + 1;
    endfunction

    task automatic add_row(input [95:0] nm, input int op, input int h, input int v,
                           input int st, input int tk, input int ef, input int ev,
                           input int cv);
        t_name[n_rows] = nm;
        t_op[n_rows] = op;
        t_h[n_rows] = h;
        t_v[n_rows] = v;
        t_streak[n_rows] = st;
        t_ticks[n_rows] = tk;
        t_flag[n_rows] = ef;
        t_val[n_rows] = ev;
        t_cv[n_rows] = cv;
        n_rows++;
    endtask

    task automatic add_combo(input [95:0] nm, input int s, input int h, input int v);
        add_row(nm, OP_COMBO, h, v, s, 0, s != 0, combo_addr_of(s, h, v), 1);
    endtask

    task automatic tick();
        repeat (2) @(posedge clk);
        frame_tick <= 1'b1;
        @(posedge clk);
        frame_tick <= 1'b0;
    endtask

    task automatic request(input int kind, input [95:0] nm, input int ef, input int ev,
                           input int cv, input int gr);
        chk_kind  <= 4'(kind);
        chk_name  <= nm;
        exp_flag  <= ef[0];
        exp_val   <= 32'(ev);
        chk_val   <= cv[0];
        exp_grade <= 2'(gr);
        chk_en    <= 1'b1;
        @(posedge clk);
        chk_en    <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int r;
        int s;
        int n;
        {frame_tick, spawn, on_track, hit_press, chk_en, exp_flag, chk_val} = '0;
        {h_cnt, v_cnt, streak, chk_kind, chk_name, exp_val, exp_grade} = '0;
        cycles = 0;
        limit  = 0;
        n_rows = 0;
        seed   = 32'h5155538a;

        add_combo("combo0", 0, 100, 150);
        add_combo("combo7", 7, 96, 145);
        add_combo("combo42", 42, 103, 176);
        add_combo("combo305", 305, 111, 160);
        add_row("combo_out", OP_COMBO, 100, 200, 42, 0, 0, 0, 1);
        foreach (t_name[i]) begin
            if (i < 6) begin
                s = (i % 2) ? 305 : 42;
                n = digit_count(s) * 16;
                r = $random(seed);
                add_combo("combo_rand", s, combo_col(s) + (r & 32'h7fffffff) % n,
                          145 + (r >>> 8 & 31));
            end
        end
        add_row("slide_in", OP_SLIDE, 300, 150, 0, 0, 1, 172 + 512 * 22, 1);
        add_row("slide_tl", OP_SLIDE, 128, 128, 0, 0, 1, 0, 1);
        add_row("slide_br", OP_SLIDE, 639, 223, 0, 0, 1, 511 + 512 * 95, 1);
        add_row("slide_left", OP_SLIDE, 127, 150, 0, 0, 0, 0, 0);
        add_row("slide_below", OP_SLIDE, 300, 224, 0, 0, 0, 0, 0);
        // Good press at x 170 after 251 frames from spawn
        add_row("spawn", OP_SPAWN, 0, 0, 0, 0, 0, 0, 0);
        add_row("move_none", OP_MOVE, 0, 0, 0, 10, 1, 2080, 1);
        add_row("move_bad", OP_MOVE, 0, 0, 0, 228, 1, 2080, 1);
        add_row("move_ok", OP_MOVE, 0, 0, 0, 10, 1, 2080, 1);
        add_row("move_good", OP_MOVE, 0, 0, 0, 3, 1, 2080, 1);
        add_row("press_good", OP_PRESS, 0, 0, 0, 1, 0, 0, 0);
        add_row("label_good", OP_LABEL, 165, 124, 0, 6, 1, 528, 1);
        add_row("ring_good", OP_RING, 166, 165, 0, 0, 1, 47 + 96 * 47, 1);
        add_row("label_gone", OP_LABEL, 165, 124, 0, 6, 0, 528, 1);
        add_row("pulses_good", OP_PULSES, 0, 0, 0, 0, 1, 1, 1);
        add_row("park", OP_PARK, 0, 0, 0, 40, 0, 0, 0);
        add_row("spawn_bad", OP_SPAWN, 0, 0, 0, 0, 0, 0, 0);
        add_row("move_bad2", OP_MOVE, 0, 0, 0, 236, 1, 2080, 1);
        add_row("press_bad", OP_PRESS, 0, 0, 0, 1, 0, 0, 0);
        add_row("label_bad", OP_LABEL, 165, 124, 0, 1, 1, 2048 + 528, 1);
        add_row("pulses_bad", OP_PULSES, 0, 0, 0, 0, 1, 1, 1);
        // Expiry on the 211th on-track tick counting the spawn tick
        add_row("spawn_exp", OP_SPAWN, 0, 0, 0, 0, 0, 0, 0);
        add_row("expire", OP_EXPIRE, 0, 0, 0, 210, 1, 0, 0);
        add_row("move_after", OP_MOVE, 0, 0, 0, 9, 1, 2080, 1);
        add_row("pulses_exp", OP_PULSES, 0, 0, 0, 0, 1, 1, 1);

        for (int i = 0; i < n_rows; i++)
            limit += (t_ticks[i] + 2) * 3 + 4;
        limit = limit * 3 + 10;

        wait (!rst);
        @(posedge clk);
        for (int i = 0; i < n_rows; i++) begin
            case (t_op[i])
                OP_COMBO, OP_SLIDE: begin
                    streak <= 10'(t_streak[i]);
                    h_cnt  <= 10'(t_h[i]);
                    v_cnt  <= 10'(t_v[i]);
                    request(t_op[i] == OP_COMBO ? K_COMBO : K_SLIDE, t_name[i],
                            t_flag[i], t_val[i], t_cv[i], 0);
                end
                OP_SPAWN: begin
                    on_track <= 1'b0;
                    tick();
                    on_track <= 1'b1;
                    spawn    <= 1'b1;
                    tick();
                    spawn    <= 1'b0;
                    note_x = 672;
                end
                OP_MOVE: begin
                    repeat (t_ticks[i]) tick();
                    note_x = note_x - 2 * t_ticks[i];
                    h_cnt <= 10'(note_x);
                    v_cnt <= 10'd165;
                    request(K_NOTE, t_name[i], 1, t_val[i], 1, grade_of(note_x));
                end
                OP_PRESS: begin
                    hit_press <= 1'b1;
                    tick();
                    hit_press <= 1'b0;
                end
                OP_PARK: begin
                    on_track <= 1'b0;
                    repeat (t_ticks[i]) tick();
                end
                OP_LABEL, OP_RING: begin
                    repeat (t_ticks[i]) tick();
                    h_cnt <= 10'(t_h[i]);
                    v_cnt <= 10'(t_v[i]);
                    @(posedge clk);       // Feedback lags the pixel by a clock
                    h_cnt <= '0;          // Pixel held for one clock only
                    v_cnt <= '0;
                    request(t_op[i] == OP_LABEL ? K_LABEL : K_RING, t_name[i],
                            t_flag[i], t_val[i], t_cv[i], 0);
                end
                OP_EXPIRE: begin
                    repeat (t_ticks[i]) tick();
                    request(K_EXPIRE, t_name[i], t_flag[i], 0, 0, 0);
                    note_x = note_x - 2 * t_ticks[i];
                end
                default: request(K_PULSES, t_name[i], 1, t_val[i], 1, 0);
            endcase
        end
        repeat (2) @(posedge clk);

        $display("Errors: %0d flag, %0d value, %0d assertion", flag_errs, value_errs,
                 dut_i.fb_i.asrt_i.fail_count);
        if (flag_errs + value_errs + dut_i.fb_i.asrt_i.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
/*
 * Testbench clock and reset, 8 ns period, reset held for 3 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire
